// ==== alu/alu_4bit.sv ====
// execute stage holding the eight-function 4-bit ALU with flags and a registered result bundle
`timescale 1ns/10ps

module alu_4bit (
	input  logic      clk,
	input  logic      rst,
	alu_op_if.sink    op,
	alu_res_if.source res
);
	import alu_pkg::*;

	logic [DATA_W:0] sum;
	logic [DATA_W:0] diff;
	data_t           b_neg;

	data_t alu_res;
	logic  alu_zero;
	logic  alu_overflow;
	logic  alu_carry;

	// carry out is the fifth bit in both cases
	assign sum   = {1'b0, op.a} + {1'b0, op.b};
	assign b_neg = ~op.b + 1'b1;
	assign diff  = {1'b0, op.a} + {1'b0, b_neg};

	always_comb begin
		alu_res      = '0;
		alu_zero     = 1'b0;
		alu_overflow = 1'b0;
		alu_carry    = 1'b0;
		case (op.fn)
			FN_ADD: begin
				alu_res   = sum[DATA_W-1:0];
				alu_carry = sum[DATA_W];
				// same-sign operands with the result sign flipped
				alu_overflow = (op.a[DATA_W-1] == op.b[DATA_W-1]) &&
				               (sum[DATA_W-1] != op.a[DATA_W-1]);
				alu_zero = (sum[DATA_W-1:0] == '0);
			end
			FN_SUB: begin
				alu_res   = diff[DATA_W-1:0];
				alu_carry = diff[DATA_W];
				// signs differ and result leaves the sign of a
				alu_overflow = (op.a[DATA_W-1] != op.b[DATA_W-1]) &&
				               (diff[DATA_W-1] != op.a[DATA_W-1]);
				alu_zero = (diff[DATA_W-1:0] == '0);
			end
			FN_NOT: begin
				alu_res = ~op.a;
			end
			FN_AND: begin
				alu_res = op.a & op.b;
			end
			FN_OR: begin
				alu_res = op.a | op.b;
			end
			FN_XOR: begin
				alu_res = op.a ^ op.b;
			end
			FN_LT: begin
				// unsigned compare
				alu_res = (op.a < op.b) ? data_t'(1) : data_t'(0);
			end
			FN_EQ: begin
				alu_res = (op.a == op.b) ? data_t'(1) : data_t'(0);
			end
			default: begin
				alu_res = '0;
			end
		endcase
	end

	// output register where the payload only moves with a valid op
	always_ff @(posedge clk) begin
		if (rst) begin
			res.valid    <= 1'b0;
			res.rd       <= '0;
			res.res      <= '0;
			res.zero     <= 1'b0;
			res.overflow <= 1'b0;
			res.carry    <= 1'b0;
		end else begin
			res.valid <= op.valid;
			if (op.valid) begin
				res.rd       <= op.rd;
				res.res      <= alu_res;
				res.zero     <= alu_zero;
				res.overflow <= alu_overflow;
				res.carry    <= alu_carry;
			end
		end
	end

endmodule

// ==== common/alu_op_if.sv ====
// decoded operation bundle, driven by the decode stage and consumed by the execute stage
`timescale 1ns/10ps

interface alu_op_if;
	import alu_pkg::*;

	// one-cycle strobe per operation
	logic     valid;
	alu_fn_t  fn;
	reg_idx_t rd;
	// operands already resolved, forwarding included
	data_t    a;
	data_t    b;

	modport source (
		output valid,
		output fn,
		output rd,
		output a,
		output b
	);

	modport sink (
		input valid,
		input fn,
		input rd,
		input a,
		input b
	);

endinterface

// ==== common/alu_pkg.sv ====
// shared widths, instruction fields and function codes, imported by the ALU datapath and its testbench
package alu_pkg;

	// datapath and register file sizes
	localparam int DATA_W   = 4;
	localparam int NUM_REGS = 4;
	localparam int REG_W    = $clog2(NUM_REGS);
	localparam int FN_W     = 3;
	localparam int INSTR_W  = 12;

	// instruction fields from the top bit down
	// [11:9] fn, [8] imm select, [7:6] rd, [5:4] ra, [3:0] rb or immediate
	localparam int FN_LSB  = 9;
	localparam int IMM_BIT = 8;
	localparam int RD_LSB  = 6;
	localparam int RA_LSB  = 4;

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [REG_W-1:0]   reg_idx_t;
	typedef logic [INSTR_W-1:0] instr_t;

	// function codes of the 4-bit ALU
	typedef enum logic [FN_W-1:0] {
		FN_ADD = 3'b000,
		FN_SUB = 3'b001,
		FN_NOT = 3'b010,
		FN_AND = 3'b011,
		FN_OR  = 3'b100,
		FN_XOR = 3'b101,
		FN_LT  = 3'b110,
		FN_EQ  = 3'b111
	} alu_fn_t;

endpackage

// ==== common/alu_res_if.sv ====
// executed result bundle, used between execute, result and decode stages for write-back and forwarding
`timescale 1ns/10ps

interface alu_res_if;
	import alu_pkg::*;

	logic     valid;
	reg_idx_t rd;
	data_t    res;
	// flags as produced by the ALU
	logic     zero;
	logic     overflow;
	logic     carry;

	modport source (
		output valid,
		output rd,
		output res,
		output zero,
		output overflow,
		output carry
	);

	modport sink (
		input valid,
		input rd,
		input res,
		input zero,
		input overflow,
		input carry
	);

endinterface

// ==== design/alu_core_top.sv ====
// top level of the pipelined ALU datapath, connecting decode, execute and result stages to plain ports
`timescale 1ns/10ps

module alu_core_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              instr_valid,
	input  alu_pkg::instr_t   instr,
	output logic              result_valid,
	output alu_pkg::reg_idx_t result_rd,
	output alu_pkg::data_t    result,
	output logic              result_zero,
	output logic              result_overflow,
	output logic              result_carry
);
	import alu_pkg::*;

	reg_idx_t rf_rd_a;
	reg_idx_t rf_rd_b;
	data_t    rf_a;
	data_t    rf_b;

	alu_op_if  dec_op ();
	alu_res_if ex_res ();
	alu_res_if wb_res ();

	alu_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rf_rd_a     (rf_rd_a),
		.rf_rd_b     (rf_rd_b),
		.rf_a        (rf_a),
		.rf_b        (rf_b),
		.ex          (ex_res.sink),
		.wb          (wb_res.sink),
		.op          (dec_op.source)
	);

	alu_4bit u_alu (
		.clk (clk),
		.rst (rst),
		.op  (dec_op.sink),
		.res (ex_res.source)
	);

	alu_result u_result (
		.clk  (clk),
		.rst  (rst),
		.ex   (ex_res.sink),
		.rd_a (rf_rd_a),
		.rd_b (rf_rd_b),
		.rf_a (rf_a),
		.rf_b (rf_b),
		.wb   (wb_res.source)
	);

	// outputs come straight from the write-back register
	assign result_valid    = wb_res.valid;
	assign result_rd       = wb_res.rd;
	assign result          = wb_res.res;
	assign result_zero     = wb_res.zero;
	assign result_overflow = wb_res.overflow;
	assign result_carry    = wb_res.carry;

endmodule

// ==== design/alu_decode.sv ====
// decode stage that samples the instruction word and resolves operands with forwarding for the ALU
`timescale 1ns/10ps

module alu_decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              instr_valid,
	input  alu_pkg::instr_t   instr,
	output alu_pkg::reg_idx_t rf_rd_a,
	output alu_pkg::reg_idx_t rf_rd_b,
	input  alu_pkg::data_t    rf_a,
	input  alu_pkg::data_t    rf_b,
	alu_res_if.sink           ex,
	alu_res_if.sink           wb,
	alu_op_if.source          op
);
	import alu_pkg::*;

	logic     valid_q;
	alu_fn_t  fn_q;
	logic     imm_sel_q;
	reg_idx_t rd_q;
	reg_idx_t ra_q;
	// low field holds either rb or the immediate
	data_t    b_field_q;

	reg_idx_t rb;
	data_t    a_val;
	data_t    b_val;

	// decode register loaded on every accepted instruction
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q   <= 1'b0;
			fn_q      <= FN_ADD;
			imm_sel_q <= 1'b0;
			rd_q      <= '0;
			ra_q      <= '0;
			b_field_q <= '0;
		end else begin
			valid_q <= instr_valid;
			if (instr_valid) begin
				fn_q      <= alu_fn_t'(instr[FN_LSB +: FN_W]);
				imm_sel_q <= instr[IMM_BIT];
				rd_q      <= instr[RD_LSB +: REG_W];
				ra_q      <= instr[RA_LSB +: REG_W];
				b_field_q <= instr[DATA_W-1:0];
			end
		end
	end

	assign rb = b_field_q[REG_W-1:0];

	assign rf_rd_a = ra_q;
	assign rf_rd_b = rb;

	// the ALU output wins over write-back, which wins over the register file
	always_comb begin
		a_val = rf_a;
		if (ex.valid && (ex.rd == ra_q)) begin
			a_val = ex.res;
		end else if (wb.valid && (wb.rd == ra_q)) begin
			a_val = wb.res;
		end
	end

	always_comb begin
		b_val = rf_b;
		if (ex.valid && (ex.rd == rb)) begin
			b_val = ex.res;
		end else if (wb.valid && (wb.rd == rb)) begin
			b_val = wb.res;
		end
	end

	assign op.valid = valid_q;
	assign op.fn    = fn_q;
	assign op.rd    = rd_q;
	assign op.a     = a_val;
	// immediate bypasses the register path
	assign op.b     = imm_sel_q ? b_field_q : b_val;

endmodule

// ==== design/alu_result.sv ====
// result stage holding the register file with write-back and the output register seen at the top-level ports
`timescale 1ns/10ps

module alu_result (
	input  logic              clk,
	input  logic              rst,
	alu_res_if.sink           ex,
	input  alu_pkg::reg_idx_t rd_a,
	input  alu_pkg::reg_idx_t rd_b,
	output alu_pkg::data_t    rf_a,
	output alu_pkg::data_t    rf_b,
	alu_res_if.source         wb
);
	import alu_pkg::*;

	data_t regs [NUM_REGS];

	// write-back from the ALU output register
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (ex.valid) begin
			regs[ex.rd] <= ex.res;
		end
	end

	// two async read ports for decode
	assign rf_a = regs[rd_a];
	assign rf_b = regs[rd_b];

	// wb mirrors ex one cycle later
	always_ff @(posedge clk) begin
		if (rst) begin
			wb.valid    <= 1'b0;
			wb.rd       <= '0;
			wb.res      <= '0;
			wb.zero     <= 1'b0;
			wb.overflow <= 1'b0;
			wb.carry    <= 1'b0;
		end else begin
			wb.valid    <= ex.valid;
			wb.rd       <= ex.rd;
			wb.res      <= ex.res;
			wb.zero     <= ex.zero;
			wb.overflow <= ex.overflow;
			wb.carry    <= ex.carry;
		end
	end

endmodule

// ==== list.f ====
common/alu_pkg.sv
common/alu_op_if.sv
common/alu_res_if.sv
design/alu_decode.sv
alu/alu_4bit.sv
design/alu_result.sv
design/alu_core_top.sv
verif/alu_core_tb.sv

// ==== verif/alu_core_tb.sv ====
// directed testbench for the pipelined ALU datapath, compiled with list.f and run with alu_core_tb as top
`timescale 1ns/10ps

module alu_core_tb;
	import alu_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 5;
	localparam int LATENCY    = 3;
	localparam int DRAIN_MAX  = 12;
	localparam int NUM_TESTS  = 6;
	// issues per test and worst-case idle cycles of the tests with gaps
	localparam int ISSUE_TOTAL = 4 + 529 + 80 + 192 + 40 + 200;
	localparam int GAP_TOTAL   = 4 + 40 * 1 + 200 * 3;
	localparam int WATCHDOG_CYCLES =
		RST_CYCLES + ISSUE_TOTAL + GAP_TOTAL + NUM_TESTS * DRAIN_MAX + 50;

	typedef struct packed {
		reg_idx_t    rd;
		data_t       res;
		logic        zero;
		logic        overflow;
		logic        carry;
		logic [31:0] edge_no;
	} expect_t;

	logic     clk;
	logic     rst;
	logic     instr_valid;
	instr_t   instr;
	logic     result_valid;
	reg_idx_t result_rd;
	data_t    result;
	logic     result_zero;
	logic     result_overflow;
	logic     result_carry;

	// register contents in program order
	data_t   model_regs [NUM_REGS];
	expect_t exp_q [$];
	int      edge_cnt = 0;
	int      err_count = 0;
	int      tests_failed = 0;
	int      issue_count = 0;
	int      seed_val;

	alu_core_top u_dut (
		.clk             (clk),
		.rst             (rst),
		.instr_valid     (instr_valid),
		.instr           (instr),
		.result_valid    (result_valid),
		.result_rd       (result_rd),
		.result          (result),
		.result_zero     (result_zero),
		.result_overflow (result_overflow),
		.result_carry    (result_carry)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 1;
	end

	// reference behaviour of one ALU operation
	function automatic expect_t expect_result(input alu_fn_t fn, input data_t a, input data_t b);
		expect_t e;
		int      sum;
		e = '0;
		case (fn)
			FN_ADD: begin
				sum        = int'(a) + int'(b);
				e.res      = sum[DATA_W-1:0];
				e.carry    = sum[DATA_W];
				e.overflow = (a[DATA_W-1] == b[DATA_W-1]) &&
				             (e.res[DATA_W-1] != a[DATA_W-1]);
				e.zero     = (e.res == 0);
			end
			FN_SUB: begin
				// a plus the two's complement of b with carry from bit 4
				sum        = int'(a) + ((16 - int'(b)) % 16);
				e.res      = sum[DATA_W-1:0];
				e.carry    = sum[DATA_W];
				e.overflow = (a[DATA_W-1] != b[DATA_W-1]) &&
				             (e.res[DATA_W-1] != a[DATA_W-1]);
				e.zero     = (e.res == 0);
			end
			FN_NOT: e.res = ~a;
			FN_AND: e.res = a & b;
			FN_OR:  e.res = a | b;
			FN_XOR: e.res = a ^ b;
			FN_LT:  e.res = (a < b) ? 4'd1 : 4'd0;
			FN_EQ:  e.res = (a == b) ? 4'd1 : 4'd0;
			default: e.res = '0;
		endcase
		return e;
	endfunction

	task automatic issue_instr(input alu_fn_t fn, input logic imm, input reg_idx_t rd,
			input reg_idx_t ra, input data_t b_field);
		instr_t  word;
		data_t   a_val;
		data_t   b_val;
		expect_t e;
		word = '0;
		word[FN_LSB +: FN_W]  = fn;
		word[IMM_BIT]         = imm;
		word[RD_LSB +: REG_W] = rd;
		word[RA_LSB +: REG_W] = ra;
		word[DATA_W-1:0]      = b_field;
		a_val = model_regs[ra];
		b_val = imm ? b_field : model_regs[b_field[REG_W-1:0]];
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= word;
		e = expect_result(fn, a_val, b_val);
		e.rd      = rd;
		e.edge_no = edge_cnt + 1;
		exp_q.push_back(e);
		model_regs[rd] = e.res;
		issue_count++;
	endtask

	// junk on instr while valid is low must be ignored
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			instr       <= instr_t'($urandom);
		end
	endtask

	task automatic wait_drain();
		int waited;
		idle_cycles(1);
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_MAX) begin
			@(posedge clk);
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			$display("pipeline did not drain: %0d results still missing after %0d cycles",
				exp_q.size(), DRAIN_MAX);
			err_count++;
			exp_q.delete();
		end
	endtask

	task automatic report_test(input string name, input int start_err, input int start_issue);
		int errs;
		errs = err_count - start_err;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %-24s %4d issues  %0d errors  %s", name, issue_count - start_issue,
			errs, (errs == 0) ? "ok" : "FAILED");
	endtask

	// checks every result cycle against the oldest outstanding issue
	always @(negedge clk) begin
		expect_t e;
		string   got;
		if (result_valid === 1'b1) begin
			assert (exp_q.size() > 0) else begin
				$display("result_valid rose at %0t ns with no instruction outstanding", $time);
				err_count++;
			end
			if (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				assert (result_rd === e.rd && result === e.res && result_zero === e.zero &&
						result_overflow === e.overflow && result_carry === e.carry) else begin
					got = $sformatf("rd=%0d res=%h z=%b v=%b c=%b", result_rd, result,
						result_zero, result_overflow, result_carry);
					$display("[FAIL] %0t ns: got %s, expected rd=%0d res=%h z=%b v=%b c=%b",
						$time, got, e.rd, e.res, e.zero, e.overflow, e.carry);
					err_count++;
				end
				assert (edge_cnt == e.edge_no + LATENCY) else begin
					$display("result for r%0d arrived %0d edges after its issue instead of %0d",
						e.rd, edge_cnt - e.edge_no, LATENCY);
					err_count++;
				end
			end
		end
	end

	task automatic reset_and_load();
		int    start_err;
		int    start_issue;
		data_t imm;
		start_err   = err_count;
		start_issue = issue_count;
		repeat (4) begin
			@(negedge clk);
			assert (result_valid === 1'b0 && result === '0 && result_rd === '0 &&
					{result_zero, result_overflow, result_carry} === 3'b000) else begin
				$display("outputs not quiet and cleared after reset at %0t ns", $time);
				err_count++;
			end
		end
		// r0 is loaded last so the others read it as zero
		for (int r = NUM_REGS - 1; r >= 0; r--) begin
			imm = data_t'($urandom_range(1, 15));
			issue_instr(FN_OR, 1'b1, reg_idx_t'(r), 2'd0, imm);
		end
		wait_drain();
		report_test("reset and register load", start_err, start_issue);
	endtask

	task automatic add_sub_sweep();
		int start_err;
		int start_issue;
		start_err   = err_count;
		start_issue = issue_count;
		issue_instr(FN_XOR, 1'b0, 2'd0, 2'd0, 4'd0);
		for (int a = 0; a < 16; a++) begin
			issue_instr(FN_OR, 1'b1, 2'd1, 2'd0, data_t'(a));
			for (int b = 0; b < 16; b++) begin
				issue_instr(FN_ADD, 1'b1, 2'd2, 2'd1, data_t'(b));
				issue_instr(FN_SUB, 1'b1, 2'd3, 2'd1, data_t'(b));
			end
		end
		wait_drain();
		report_test("add and subtract sweep", start_err, start_issue);
	endtask

	task automatic logic_ops();
		int      start_err;
		int      start_issue;
		alu_fn_t fn;
		start_err   = err_count;
		start_issue = issue_count;
		for (int i = 0; i < 8; i++) begin
			issue_instr(FN_OR, 1'b1, 2'd1, 2'd0, data_t'($urandom));
			issue_instr(FN_OR, 1'b1, 2'd2, 2'd0, data_t'($urandom));
			// NOT, AND, OR, XOR have consecutive codes
			for (int k = 0; k < 4; k++) begin
				fn = alu_fn_t'(int'(FN_NOT) + k);
				issue_instr(fn, 1'b0, 2'd3, 2'd1, 4'd2);
				issue_instr(fn, 1'b1, 2'd3, 2'd1, data_t'($urandom));
			end
		end
		wait_drain();
		report_test("bitwise operations", start_err, start_issue);
	endtask

	task automatic compare_ops();
		int    start_err;
		int    start_issue;
		data_t a;
		data_t b;
		start_err   = err_count;
		start_issue = issue_count;
		for (int i = 0; i < 32; i++) begin
			a = data_t'($urandom);
			b = (i % 4 == 0) ? a : data_t'($urandom);
			issue_instr(FN_OR, 1'b1, 2'd1, 2'd0, a);
			issue_instr(FN_OR, 1'b1, 2'd2, 2'd0, b);
			issue_instr(FN_LT, 1'b0, 2'd3, 2'd1, 4'd2);
			issue_instr(FN_EQ, 1'b0, 2'd3, 2'd1, 4'd2);
			issue_instr(FN_LT, 1'b1, 2'd3, 2'd1, b);
			issue_instr(FN_EQ, 1'b1, 2'd3, 2'd1, b);
		end
		wait_drain();
		report_test("compare operations", start_err, start_issue);
	endtask

	task automatic dependent_chains();
		int       start_err;
		int       start_issue;
		reg_idx_t prev;
		reg_idx_t rd;
		logic     imm;
		data_t    b_field;
		start_err   = err_count;
		start_issue = issue_count;
		prev = 2'd1;
		for (int i = 0; i < 40; i++) begin
			rd      = reg_idx_t'($urandom);
			imm     = 1'($urandom);
			b_field = data_t'($urandom);
			// every other register-mode op also takes b from the predecessor
			if (!imm && (i % 2 == 0)) begin
				b_field = {2'b00, prev};
			end
			issue_instr(alu_fn_t'($urandom_range(0, 7)), imm, rd, prev, b_field);
			prev = rd;
			if ($urandom_range(0, 1) == 1) begin
				idle_cycles(1);
			end
		end
		wait_drain();
		report_test("dependent chains", start_err, start_issue);
	endtask

	task automatic random_stream();
		int start_err;
		int start_issue;
		start_err   = err_count;
		start_issue = issue_count;
		for (int i = 0; i < 200; i++) begin
			issue_instr(alu_fn_t'($urandom_range(0, 7)), 1'($urandom), reg_idx_t'($urandom),
				reg_idx_t'($urandom), data_t'($urandom));
			idle_cycles($urandom_range(0, 3));
		end
		wait_drain();
		report_test("random stream", start_err, start_issue);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		seed_val    = $urandom(73476);
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;

		reset_and_load();
		add_sub_sweep();
		logic_ops();
		compare_ops();
		dependent_chains();
		random_stream();

		$display("%0d tests, %0d with errors, %0d instructions issued, %0d errors in total",
			NUM_TESTS, tests_failed, issue_count, err_count);
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
